// File: logic/scope_params.svh
//--------------------
// Capture core constants
// Host register map and request word bits
// Sample, reply word and buffer sizes
// Post-trigger sample count
//--------------------
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// Host write port
`define REG_ADDR_WIDTH 8
`define REG_DATA_WIDTH 16

// One channel sample, zero-extended into a reply word
`define SAMPLE_WIDTH 12

// Circular buffer, entries per channel
`define BUF_DEPTH_LOG2 5
`define BUF_DEPTH (1 << `BUF_DEPTH_LOG2)
// Fill count must also hold the full depth
`define FILL_WIDTH (`BUF_DEPTH_LOG2 + 1)

// Samples kept after the trigger sample before the automatic stop
`define POST_TRIG_SAMPLES 8
`define POST_CNT_WIDTH 4

// Register addresses
`define RQST_REG_ADDR 1
`define TRIG_REG_ADDR 2

// Request word bits, RST is the highest one in use
`define RQST_START_IDX 0
`define RQST_STOP_IDX 1
`define RQST_CHA_IDX 2
`define RQST_CHB_IDX 3
`define RQST_TRIG_IDX 4
`define RQST_RST_IDX 5

`endif

// File: logic/scope_pkg.sv
//--------------------
// Shared types of the capture core
// Capture FSM states
// Reply stream kinds
//--------------------
package scope_pkg;

    // Capture FSM
    // Code goes out as is in status bits 1:0
    typedef enum logic [1:0] {
        // Nothing stored since the last clear
        CAP_IDLE    = 2'd0,
        // Storing every valid sample pair
        CAP_RUNNING = 2'd1,
        // Buffer frozen, safe to read
        CAP_STOPPED = 2'd2
    } capture_state_t;

    // What the reply stream carries right now
    typedef enum logic [1:0] {
        // Streamer idle
        REPLY_NONE   = 2'd0,
        // Stored channel 1 samples, oldest first
        REPLY_CH1    = 2'd1,
        // Stored channel 2 samples, oldest first
        REPLY_CH2    = 2'd2,
        // Single status word
        REPLY_STATUS = 2'd3
    } reply_kind_t;

endpackage

// File: logic/request_decoder.sv
//--------------------
// Host request decoder
// Request register to one-cycle pulses
// Trigger level register
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module request_decoder #(
    parameter logic [`REG_ADDR_WIDTH-1:0] rqst_addr = `RQST_REG_ADDR,
    parameter logic [`REG_ADDR_WIDTH-1:0] trig_addr = `TRIG_REG_ADDR
) (
    input  logic                       clk,
    input  logic                       rst,

    // Host write strobe port
    input  logic [`REG_ADDR_WIDTH-1:0] si_addr,
    input  logic [`REG_DATA_WIDTH-1:0] si_data,
    input  logic                       si_rdy,

    // Request pulses, one cycle each
    output logic                       start,
    output logic                       stop,
    output logic                       rqst_ch1,
    output logic                       rqst_ch2,
    output logic                       rqst_status,
    output logic                       clear,

    // Held trigger level
    output logic [`SAMPLE_WIDTH-1:0]   trig_level
);

    // Request bits seen on the last write, zero otherwise
    logic [`RQST_RST_IDX:0] rqst_word;
    logic                   rqst_hit;

    assign rqst_hit = si_rdy && (si_addr == rqst_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            rqst_word <= '0;
        end else if (rqst_hit) begin
            rqst_word <= si_data[`RQST_RST_IDX:0];
        end else begin
            // Bits drop after one cycle
            rqst_word <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Highest level, a capture rarely triggers before the host sets it
            trig_level <= '1;
        end else if (si_rdy && (si_addr == trig_addr)) begin
            trig_level <= si_data[`SAMPLE_WIDTH-1:0];
        end
    end

    assign start       = rqst_word[`RQST_START_IDX];
    // Channel reads also freeze the buffer so no write races the read
    assign stop        = rqst_word[`RQST_STOP_IDX] | rqst_word[`RQST_CHA_IDX]
                       | rqst_word[`RQST_CHB_IDX];
    assign rqst_ch1    = rqst_word[`RQST_CHA_IDX];
    assign rqst_ch2    = rqst_word[`RQST_CHB_IDX];
    assign rqst_status = rqst_word[`RQST_TRIG_IDX];
    assign clear       = rqst_word[`RQST_RST_IDX];

    // A pulse only repeats when the host writes the request register again
    a_pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (|rqst_word) && !rqst_hit |=> !(|rqst_word));

endmodule

// File: logic/capture_sequencer.sv
//--------------------
// Capture sequencer
// Capture FSM with request priority
// Circular write pointer and fill count
// Trigger compare and post-trigger stop
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module capture_sequencer (
    input  logic                        clk,
    input  logic                        rst,

    // Request pulses and trigger level
    input  logic                        start,
    input  logic                        stop,
    input  logic                        clear,
    input  logic [`SAMPLE_WIDTH-1:0]    trig_level,

    // Incoming sample pair
    input  logic [`SAMPLE_WIDTH-1:0]    ch1_in,
    input  logic [`SAMPLE_WIDTH-1:0]    ch2_in,
    input  logic                        sample_valid,

    // Buffer write port
    output logic                        wr_en,
    output logic [`BUF_DEPTH_LOG2-1:0]  wr_addr,
    output logic [`SAMPLE_WIDTH-1:0]    wr_ch1,
    output logic [`SAMPLE_WIDTH-1:0]    wr_ch2,

    // Stored window, for the streamer
    output logic [`BUF_DEPTH_LOG2-1:0]  oldest_addr,
    output logic [`FILL_WIDTH-1:0]      fill_count,
    output scope_pkg::capture_state_t   state,
    output logic                        triggered
);

    localparam logic [`FILL_WIDTH-1:0]    full_count = `FILL_WIDTH'(`BUF_DEPTH);
    localparam logic [`POST_CNT_WIDTH-1:0] post_trig = `POST_CNT_WIDTH'(`POST_TRIG_SAMPLES);

    logic [`BUF_DEPTH_LOG2-1:0] wr_ptr;
    // Samples still to store after the trigger
    logic [`POST_CNT_WIDTH-1:0] post_cnt;
    logic                       store;
    logic                       hit;

    // A control pulse takes the cycle, so the stored window is final
    // by the time a read request is seen
    assign store = (state == scope_pkg::CAP_RUNNING) && sample_valid
                 && !(start || stop || clear);

    // Only the first qualifying sample triggers
    assign hit = !triggered && (ch1_in >= trig_level);

    assign wr_en   = store;
    assign wr_addr = wr_ptr;
    assign wr_ch1  = ch1_in;
    assign wr_ch2  = ch2_in;

    // Full buffer gives zero low bits, so oldest is the write pointer
    assign oldest_addr = wr_ptr - fill_count[`BUF_DEPTH_LOG2-1:0];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            // Clear wins over stop and start
            state      <= scope_pkg::CAP_IDLE;
            wr_ptr     <= '0;
            fill_count <= '0;
            triggered  <= 1'b0;
            post_cnt   <= '0;
        end else if (stop) begin
            // Stop wins over start
            state <= scope_pkg::CAP_STOPPED;
        end else if (start) begin
            state      <= scope_pkg::CAP_RUNNING;
            wr_ptr     <= '0;
            fill_count <= '0;
            triggered  <= 1'b0;
            post_cnt   <= '0;
        end else if (store) begin
            // Wraps at the buffer depth
            wr_ptr <= wr_ptr + 1'b1;
            // Saturates once the buffer is full
            if (fill_count != full_count) begin
                fill_count <= fill_count + 1'b1;
            end
            if (hit) begin
                triggered <= 1'b1;
                post_cnt  <= post_trig;
                if (post_trig == '0) begin
                    state <= scope_pkg::CAP_STOPPED;
                end
            end else if (triggered) begin
                post_cnt <= post_cnt - 1'b1;
                // Last post-trigger sample just stored
                if (post_cnt == `POST_CNT_WIDTH'(1)) begin
                    state <= scope_pkg::CAP_STOPPED;
                end
            end
        end
    end

    a_fill_bounded: assert property (@(posedge clk) disable iff (rst)
        fill_count <= full_count);

    a_wr_only_running: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> state == scope_pkg::CAP_RUNNING);

endmodule

// File: logic/sample_buffer.sv
//--------------------
// Sample buffer
// Two-channel circular RAM
// One write port, registered read
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module sample_buffer #(
    parameter int depth_log2 = `BUF_DEPTH_LOG2
) (
    input  logic                      clk,

    // Write port from the sequencer
    input  logic                      wr_en,
    input  logic [depth_log2-1:0]     wr_addr,
    input  logic [`SAMPLE_WIDTH-1:0]  wr_ch1,
    input  logic [`SAMPLE_WIDTH-1:0]  wr_ch2,

    // Read port from the streamer, data one cycle later
    input  logic [depth_log2-1:0]     rd_addr,
    output logic [`SAMPLE_WIDTH-1:0]  rd_ch1,
    output logic [`SAMPLE_WIDTH-1:0]  rd_ch2
);

    localparam int depth = 1 << depth_log2;

    // Pair per entry, ch2 in the upper half
    logic [2*`SAMPLE_WIDTH-1:0] mem [depth];
    logic [2*`SAMPLE_WIDTH-1:0] wr_pair;
    logic [2*`SAMPLE_WIDTH-1:0] rd_pair;

    assign wr_pair = {wr_ch2, wr_ch1};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pair;
        end
    end

    // Write-first on an address match
    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr == rd_addr)) begin
            rd_pair <= wr_pair;
        end else begin
            rd_pair <= mem[rd_addr];
        end
    end

    assign rd_ch1 = rd_pair[`SAMPLE_WIDTH-1:0];
    assign rd_ch2 = rd_pair[2*`SAMPLE_WIDTH-1:`SAMPLE_WIDTH];

endmodule

// File: logic/reply_streamer.sv
//--------------------
// Reply streamer
// Channel data stream, oldest first
// One-word status reply
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module reply_streamer (
    input  logic                        clk,
    input  logic                        rst,

    // Read and status request pulses
    input  logic                        rqst_ch1,
    input  logic                        rqst_ch2,
    input  logic                        rqst_status,

    // Stored window and status from the sequencer
    input  logic [`BUF_DEPTH_LOG2-1:0]  oldest_addr,
    input  logic [`FILL_WIDTH-1:0]      fill_count,
    input  scope_pkg::capture_state_t   state,
    input  logic                        triggered,

    // Buffer read port
    output logic [`BUF_DEPTH_LOG2-1:0]  rd_addr,
    input  logic [`SAMPLE_WIDTH-1:0]    rd_ch1,
    input  logic [`SAMPLE_WIDTH-1:0]    rd_ch2,

    // Reply stream
    output logic [`REG_DATA_WIDTH-1:0]  reply_data,
    output logic                        reply_valid,
    output logic                        reply_last,
    output scope_pkg::reply_kind_t      reply_kind
);

    localparam int pad_w = `REG_DATA_WIDTH - `SAMPLE_WIDTH;

    // Reads still to issue
    logic [`FILL_WIDTH-1:0]     remaining;
    // Read in flight, its word shows next cycle
    logic                       issuing;
    logic                       last_read;
    // Empty buffer, reply is a single zero word
    logic                       empty_q;
    logic [`REG_DATA_WIDTH-1:0] status_q;

    assign last_read = remaining <= `FILL_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            reply_kind  <= scope_pkg::REPLY_NONE;
            issuing     <= 1'b0;
            remaining   <= '0;
            reply_valid <= 1'b0;
            reply_last  <= 1'b0;
            empty_q     <= 1'b0;
        end else begin
            // Valid and last follow the read by one cycle
            reply_valid <= issuing;
            reply_last  <= issuing && last_read;
            if (issuing) begin
                rd_addr <= rd_addr + 1'b1;
                if (last_read) begin
                    issuing <= 1'b0;
                end else begin
                    remaining <= remaining - 1'b1;
                end
            end
            // Back to idle after the last word
            if (reply_valid && reply_last) begin
                reply_kind <= scope_pkg::REPLY_NONE;
            end
            // New requests only while idle, ch1 first
            if (reply_kind == scope_pkg::REPLY_NONE) begin
                if (rqst_ch1 || rqst_ch2) begin
                    reply_kind <= rqst_ch1 ? scope_pkg::REPLY_CH1 : scope_pkg::REPLY_CH2;
                    rd_addr    <= oldest_addr;
                    remaining  <= fill_count;
                    empty_q    <= (fill_count == '0);
                    issuing    <= 1'b1;
                end else if (rqst_status) begin
                    reply_kind  <= scope_pkg::REPLY_STATUS;
                    reply_valid <= 1'b1;
                    reply_last  <= 1'b1;
                    // Triggered in bit 2, state code in bits 1:0
                    status_q    <= {{(`REG_DATA_WIDTH-3){1'b0}}, triggered, state};
                end
            end
        end
    end

    always_comb begin
        case (reply_kind)
            scope_pkg::REPLY_CH1:    reply_data = empty_q ? '0 : {{pad_w{1'b0}}, rd_ch1};
            scope_pkg::REPLY_CH2:    reply_data = empty_q ? '0 : {{pad_w{1'b0}}, rd_ch2};
            scope_pkg::REPLY_STATUS: reply_data = status_q;
            default:                 reply_data = '0;
        endcase
    end

    a_last_has_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(reply_last) |-> reply_valid);

endmodule

// File: logic/scope_core.sv
//--------------------
// Acquisition core top level
// Decoder, sequencer, sample buffer
// and reply streamer
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module scope_core (
    input  logic                        clk,
    input  logic                        rst,

    // Host write port
    input  logic [`REG_ADDR_WIDTH-1:0]  si_addr,
    input  logic [`REG_DATA_WIDTH-1:0]  si_data,
    input  logic                        si_rdy,

    // Sample port
    input  logic [`SAMPLE_WIDTH-1:0]    ch1_sample,
    input  logic [`SAMPLE_WIDTH-1:0]    ch2_sample,
    input  logic                        sample_valid,

    // Reply stream
    output logic [`REG_DATA_WIDTH-1:0]  reply_data,
    output logic                        reply_valid,
    output logic                        reply_last,
    output scope_pkg::reply_kind_t      reply_kind,

    // Status levels
    output scope_pkg::capture_state_t   cap_state,
    output logic                        triggered
);

    // Decoder pulses
    logic                       start;
    logic                       stop;
    logic                       rqst_ch1;
    logic                       rqst_ch2;
    logic                       rqst_status;
    logic                       clear;
    logic [`SAMPLE_WIDTH-1:0]   trig_level;

    // Buffer ports
    logic                       wr_en;
    logic [`BUF_DEPTH_LOG2-1:0] wr_addr;
    logic [`SAMPLE_WIDTH-1:0]   wr_ch1;
    logic [`SAMPLE_WIDTH-1:0]   wr_ch2;
    logic [`BUF_DEPTH_LOG2-1:0] rd_addr;
    logic [`SAMPLE_WIDTH-1:0]   rd_ch1;
    logic [`SAMPLE_WIDTH-1:0]   rd_ch2;

    // Stored window
    logic [`BUF_DEPTH_LOG2-1:0] oldest_addr;
    logic [`FILL_WIDTH-1:0]     fill_count;

    request_decoder #(
        .rqst_addr (`REG_ADDR_WIDTH'(`RQST_REG_ADDR)),
        .trig_addr (`REG_ADDR_WIDTH'(`TRIG_REG_ADDR))
    ) u_decoder (
        .clk         (clk),
        .rst         (rst),
        .si_addr     (si_addr),
        .si_data     (si_data),
        .si_rdy      (si_rdy),
        .start       (start),
        .stop        (stop),
        .rqst_ch1    (rqst_ch1),
        .rqst_ch2    (rqst_ch2),
        .rqst_status (rqst_status),
        .clear       (clear),
        .trig_level  (trig_level)
    );

    capture_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .stop         (stop),
        .clear        (clear),
        .trig_level   (trig_level),
        .ch1_in       (ch1_sample),
        .ch2_in       (ch2_sample),
        .sample_valid (sample_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_ch1       (wr_ch1),
        .wr_ch2       (wr_ch2),
        .oldest_addr  (oldest_addr),
        .fill_count   (fill_count),
        .state        (cap_state),
        .triggered    (triggered)
    );

    sample_buffer #(
        .depth_log2 (`BUF_DEPTH_LOG2)
    ) u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_ch1  (wr_ch1),
        .wr_ch2  (wr_ch2),
        .rd_addr (rd_addr),
        .rd_ch1  (rd_ch1),
        .rd_ch2  (rd_ch2)
    );

    reply_streamer u_streamer (
        .clk         (clk),
        .rst         (rst),
        .rqst_ch1    (rqst_ch1),
        .rqst_ch2    (rqst_ch2),
        .rqst_status (rqst_status),
        .oldest_addr (oldest_addr),
        .fill_count  (fill_count),
        .state       (cap_state),
        .triggered   (triggered),
        .rd_addr     (rd_addr),
        .rd_ch1      (rd_ch1),
        .rd_ch2      (rd_ch2),
        .reply_data  (reply_data),
        .reply_valid (reply_valid),
        .reply_last  (reply_last),
        .reply_kind  (reply_kind)
    );

endmodule

// File: tests/scope_core_tb.sv
//--------------------
// Capture core testbench
// Clock, reset and LFSR sample source
// Buffer mirror and compare tasks
// Directed tests and summary
//--------------------
`timescale 1ns/10ps

`include "scope_params.svh"

module scope_core_tb;

    localparam int depth      = `BUF_DEPTH;
    // Cycles per test: reset, status, readout, wrap, trigger, misc
    localparam int run_cycles = 5 + 20 + 60 + 95 + 70 + 120;
    localparam int run_limit  = 4 * run_cycles + 400;
    // First reply word is due two cycles after the pulse
    localparam int reply_wait = 8;

    logic                       clk;
    logic                       rst;
    logic [`REG_ADDR_WIDTH-1:0] si_addr;
    logic [`REG_DATA_WIDTH-1:0] si_data;
    logic                       si_rdy;
    logic [`SAMPLE_WIDTH-1:0]   ch1_sample;
    logic [`SAMPLE_WIDTH-1:0]   ch2_sample;
    logic                       sample_valid;
    logic [`REG_DATA_WIDTH-1:0] reply_data;
    logic                       reply_valid;
    logic                       reply_last;
    scope_pkg::reply_kind_t     reply_kind;
    scope_pkg::capture_state_t  cap_state;
    logic                       triggered;

    // Mirror of the buffer and of the expected capture state
    logic [`SAMPLE_WIDTH-1:0]   mirror_ch1 [depth];
    logic [`SAMPLE_WIDTH-1:0]   mirror_ch2 [depth];
    int                         mirror_ptr;
    int                         mirror_fill;
    int                         post_left;
    logic                       model_trig;
    logic [`SAMPLE_WIDTH-1:0]   model_level;
    scope_pkg::capture_state_t  model_state;

    logic [31:0]                lfsr;
    logic [`REG_DATA_WIDTH-1:0] reply_words [$];
    int                         errors = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;
    int                         cycle_count = 0;

    scope_core uut (
        .clk          (clk),
        .rst          (rst),
        .si_addr      (si_addr),
        .si_data      (si_data),
        .si_rdy       (si_rdy),
        .ch1_sample   (ch1_sample),
        .ch2_sample   (ch2_sample),
        .sample_valid (sample_valid),
        .reply_data   (reply_data),
        .reply_valid  (reply_valid),
        .reply_last   (reply_last),
        .reply_kind   (reply_kind),
        .cap_state    (cap_state),
        .triggered    (triggered)
    );

    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= run_limit) begin
            $display("Timeout after %0d cycles, a test is stuck", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Galois LFSR, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [`SAMPLE_WIDTH-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[`SAMPLE_WIDTH-2:0], lfsr[0]};
        end
    endtask

    // Status reply layout: triggered in bit 2, state code below
    function automatic logic [`REG_DATA_WIDTH-1:0] status_word(
        input logic trig, input scope_pkg::capture_state_t st);
        logic [`REG_DATA_WIDTH-1:0] w;
        w = '0;
        w[2] = trig;
        w[1:0] = st;
        return w;
    endfunction

    task automatic compare_word(input string name, input logic [`REG_DATA_WIDTH-1:0] exp,
                                input logic [`REG_DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_state(input string name, input scope_pkg::capture_state_t exp,
                                 input scope_pkg::capture_state_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
            errors++;
        end
    endtask

    task automatic compare_kind(input string name, input scope_pkg::reply_kind_t exp,
                                input scope_pkg::reply_kind_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
            errors++;
        end
    endtask

    // Triggered status level
    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected triggered %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // One strobed register write, taken at the second edge
    task automatic host_write(input logic [`REG_ADDR_WIDTH-1:0] addr,
                              input logic [`REG_DATA_WIDTH-1:0] data);
        @(posedge clk);
        si_addr <= addr;
        si_data <= data;
        si_rdy  <= 1'b1;
        @(posedge clk);
        si_rdy  <= 1'b0;
    endtask

    task automatic set_level(input logic [`SAMPLE_WIDTH-1:0] level);
        host_write(`REG_ADDR_WIDTH'(`TRIG_REG_ADDR), `REG_DATA_WIDTH'(level));
        model_level = level;
    endtask

    // Single request bit, plus its effect on the expected state
    task automatic request(input int idx);
        host_write(`REG_ADDR_WIDTH'(`RQST_REG_ADDR), `REG_DATA_WIDTH'(1 << idx));
        case (idx)
            `RQST_START_IDX, `RQST_RST_IDX: begin
                model_state = (idx == `RQST_START_IDX) ? scope_pkg::CAP_RUNNING
                                                       : scope_pkg::CAP_IDLE;
                mirror_ptr  = 0;
                mirror_fill = 0;
                model_trig  = 1'b0;
                post_left   = 0;
            end
            // Channel reads freeze the buffer too
            `RQST_STOP_IDX, `RQST_CHA_IDX, `RQST_CHB_IDX: model_state = scope_pkg::CAP_STOPPED;
            default: ;
        endcase
    endtask

    // One sample pair; the mirror stores it only while running
    task automatic drive_sample(input logic [`SAMPLE_WIDTH-1:0] c1,
                                input logic [`SAMPLE_WIDTH-1:0] c2);
        @(posedge clk);
        ch1_sample   <= c1;
        ch2_sample   <= c2;
        sample_valid <= 1'b1;
        if (model_state == scope_pkg::CAP_RUNNING) begin
            mirror_ch1[mirror_ptr] = c1;
            mirror_ch2[mirror_ptr] = c2;
            mirror_ptr = (mirror_ptr + 1) % depth;
            if (mirror_fill < depth) begin
                mirror_fill++;
            end
            if (!model_trig && c1 >= model_level) begin
                model_trig = 1'b1;
                post_left  = `POST_TRIG_SAMPLES;
            end else if (model_trig) begin
                post_left--;
                // Automatic stop after the post-trigger samples
                if (post_left == 0) begin
                    model_state = scope_pkg::CAP_STOPPED;
                end
            end
        end
    endtask

    task automatic end_samples;
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // Random pairs, ch1 narrowed to stay under a high trigger level
    task automatic drive_random(input int n, input int ch1_bits);
        logic [`SAMPLE_WIDTH-1:0] c1;
        logic [`SAMPLE_WIDTH-1:0] c2;
        for (int i = 0; i < n; i++) begin
            take_bits(ch1_bits, c1);
            take_bits(`SAMPLE_WIDTH, c2);
            drive_sample(c1, c2);
        end
        end_samples();
    endtask

    // Gathers one reply stream into reply_words
    task automatic collect_reply(input string name, input scope_pkg::reply_kind_t exp_kind);
        int  wait_cnt;
        logic done;
        wait_cnt = 0;
        done = 1'b0;
        reply_words.delete();
        @(negedge clk);
        while (!reply_valid && wait_cnt < reply_wait) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!reply_valid) begin
            $display("[ERROR] %s: no reply word within %0d cycles", name, reply_wait);
            errors++;
            done = 1'b1;
        end
        while (!done) begin
            compare_kind(name, exp_kind, reply_kind);
            reply_words.push_back(reply_data);
            if (reply_last) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
                if (!reply_valid) begin
                    $display("[ERROR] %s: reply stream broke off before its last word", name);
                    errors++;
                    done = 1'b1;
                end
            end
        end
    endtask

    // Stored samples oldest first, or one zero word when empty
    task automatic check_samples(input string name, input int ch);
        int count;
        int idx;
        logic [`SAMPLE_WIDTH-1:0] s;
        count = (mirror_fill == 0) ? 1 : mirror_fill;
        if (reply_words.size() != count) begin
            $display("[ERROR] %s: expected %0d words, actual %0d", name, count,
                     reply_words.size());
            errors++;
        end
        for (int i = 0; i < count && i < reply_words.size(); i++) begin
            idx = (mirror_ptr + depth - mirror_fill + i) % depth;
            s = (ch == 1) ? mirror_ch1[idx] : mirror_ch2[idx];
            if (mirror_fill == 0) begin
                s = '0;
            end
            compare_word(name, `REG_DATA_WIDTH'(s), reply_words[i]);
        end
    endtask

    task automatic read_channel(input string name, input int ch);
        request((ch == 1) ? `RQST_CHA_IDX : `RQST_CHB_IDX);
        collect_reply(name, (ch == 1) ? scope_pkg::REPLY_CH1 : scope_pkg::REPLY_CH2);
        check_samples(name, ch);
    endtask

    task automatic read_status(input string name);
        request(`RQST_TRIG_IDX);
        collect_reply(name, scope_pkg::REPLY_STATUS);
        if (reply_words.size() != 1) begin
            $display("[ERROR] %s: expected 1 status word, actual %0d", name,
                     reply_words.size());
            errors++;
        end else begin
            compare_word(name, status_word(model_trig, model_state), reply_words[0]);
        end
    endtask

    // Nothing may show on the reply port for n cycles
    task automatic expect_quiet(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (reply_valid) begin
                $display("[ERROR] %s: reply word appeared with no request pending", name);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic reset_status;
        int e0;
        e0 = errors;
        @(negedge clk);
        compare_state("reset_status", scope_pkg::CAP_IDLE, cap_state);
        compare_kind("reset_status", scope_pkg::REPLY_NONE, reply_kind);
        compare_flag("reset_status", 1'b0, triggered);
        read_status("reset_status");
        finish_test("reset_status", e0);
    endtask

    task automatic capture_readout;
        int e0;
        e0 = errors;
        set_level('1);
        request(`RQST_START_IDX);
        drive_random(20, `SAMPLE_WIDTH - 1);
        read_channel("capture_readout", 1);
        @(negedge clk);
        compare_state("capture_readout", scope_pkg::CAP_STOPPED, cap_state);
        compare_flag("capture_readout", 1'b0, triggered);
        finish_test("capture_readout", e0);
    endtask

    task automatic wrap_around;
        int e0;
        e0 = errors;
        request(`RQST_START_IDX);
        drive_random(45, `SAMPLE_WIDTH - 1);
        request(`RQST_STOP_IDX);
        read_channel("wrap_around", 2);
        finish_test("wrap_around", e0);
    endtask

    task automatic trigger_stop;
        int e0;
        int trig_at;
        logic [`SAMPLE_WIDTH-1:0] c1;
        logic [`SAMPLE_WIDTH-1:0] c2;
        e0 = errors;
        trig_at = 5;
        set_level(`SAMPLE_WIDTH'('h800));
        request(`RQST_START_IDX);
        for (int k = 1; k <= trig_at + `POST_TRIG_SAMPLES + 6; k++) begin
            take_bits(`SAMPLE_WIDTH - 1, c1);
            take_bits(`SAMPLE_WIDTH, c2);
            // Sample trig_at is the first one at or above the level
            if (k == trig_at) begin
                c1 = `SAMPLE_WIDTH'('h900);
            end else if (k > trig_at) begin
                take_bits(`SAMPLE_WIDTH, c1);
            end
            drive_sample(c1, c2);
        end
        end_samples();
        @(negedge clk);
        compare_state("trigger_stop", scope_pkg::CAP_STOPPED, cap_state);
        compare_flag("trigger_stop", 1'b1, triggered);
        read_status("trigger_stop");
        read_channel("trigger_stop", 1);
        if (reply_words.size() != trig_at + `POST_TRIG_SAMPLES) begin
            $display("[ERROR] trigger_stop: expected %0d stored samples, actual %0d",
                     trig_at + `POST_TRIG_SAMPLES, reply_words.size());
            errors++;
        end
        finish_test("trigger_stop", e0);
    endtask

    task automatic ignored_writes;
        int e0;
        e0 = errors;
        // Every request bit set, but at an unused address
        host_write(`REG_ADDR_WIDTH'('h07), '1);
        expect_quiet("ignored_writes", 6);
        compare_state("ignored_writes", scope_pkg::CAP_STOPPED, cap_state);
        // ch2 request lands while the ch1 reply streams
        request(`RQST_CHA_IDX);
        request(`RQST_CHB_IDX);
        collect_reply("ignored_writes", scope_pkg::REPLY_CH1);
        check_samples("ignored_writes", 1);
        expect_quiet("ignored_writes", 6);
        request(`RQST_RST_IDX);
        repeat (2) @(negedge clk);
        compare_state("ignored_writes", scope_pkg::CAP_IDLE, cap_state);
        compare_flag("ignored_writes", 1'b0, triggered);
        // Empty buffer reads back as a single zero word
        read_channel("ignored_writes", 1);
        finish_test("ignored_writes", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst          <= 1'b1;
        si_addr      <= '0;
        si_data      <= '0;
        si_rdy       <= 1'b0;
        ch1_sample   <= '0;
        ch2_sample   <= '0;
        sample_valid <= 1'b0;
        lfsr        = 32'h1d6c_f359;
        mirror_ptr  = 0;
        mirror_fill = 0;
        post_left   = 0;
        model_trig  = 1'b0;
        model_level = '1;
        model_state = scope_pkg::CAP_IDLE;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        reset_status();
        capture_readout();
        wrap_around();
        trigger_stop();
        ignored_writes();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
logic/scope_pkg.sv
logic/request_decoder.sv
logic/capture_sequencer.sv
logic/sample_buffer.sv
logic/reply_streamer.sv
logic/scope_core.sv
tests/scope_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the capture core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module scope_core_tb -o scope_sim

output=$(./obj_dir/scope_sim)
echo "$output"

# Exit status follows the pass line in the output
echo "$output" | grep -q "PASS: all tests"
